// ==== files.f ====
verilog/tart_pkg.sv
verilog/sample_mem.sv
verilog/antenna_capture.sv
verilog/acq_scheduler.sv
verilog/mem_arbiter.sv
verilog/spi_readout.sv
verilog/tart_capture_top.sv
dv/tart_capture_props.sv
dv/tb_tart_capture.sv

// ==== Bender.yml ====
package:
  name: tart_capture

sources:
  - verilog/tart_pkg.sv
  - verilog/sample_mem.sv
  - verilog/antenna_capture.sv
  - verilog/acq_scheduler.sv
  - verilog/mem_arbiter.sv
  - verilog/spi_readout.sv
  - verilog/tart_capture_top.sv
  - target: test
    files:
      - dv/tart_capture_props.sv
      - dv/tb_tart_capture.sv

// ==== dv/tb_tart_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tart_capture;
   import tart_pkg::*;

   localparam int CLK_HALF   = 4;
   localparam int RST_CYCLES = 8;
   localparam int SCK_HALF   = 12;
   localparam int LED_LIMIT  = 4000;
   localparam int STB_LIMIT  = 20;

   logic        fpga_clk;
   logic        arst_n;
   sample_t     antenna;
   logic        spi_sck;
   logic        spi_mosi;
   logic        spi_ssel;
   logic        spi_miso;
   logic        led;
   logic        sample_test_pin;
   integer      seed;
   int          checks;
   int          errors;
   int          assert_errs;
   logic        timed_out;
   int unsigned cyc = 0;
   sample_t     rec [REC_DEPTH];

   tart_capture_top u_tart_capture_top
   (
      .fpga_clk        (fpga_clk),
      .arst_n          (arst_n),
      .antenna         (antenna),
      .spi_sck         (spi_sck),
      .spi_mosi        (spi_mosi),
      .spi_ssel        (spi_ssel),
      .spi_miso        (spi_miso),
      .led             (led),
      .sample_test_pin (sample_test_pin)
   );

   bind tart_capture_top tart_capture_props u_tart_capture_props
   (
      .fpga_clk   (fpga_clk),
      .arst_n     (arst_n),
      .wr_req     (wr_req),
      .rd_req     (rd_req),
      .wr_gnt     (wr_gnt),
      .rd_gnt     (rd_gnt),
      .rd_valid   (rd_valid),
      .start      (ctrl.start),
      .soft_reset (soft_reset),
      .running    (running),
      .done       (done),
      .overflow   (overflow)
   );

   initial
   begin
      fpga_clk = 1'b0;
      forever #CLK_HALF fpga_clk = ~fpga_clk;
   end

   // cycle stamp for strobe spacing
   always @(posedge fpga_clk)
      cyc <= cyc + 1;

   task automatic compare_value(input string sig, input logic [31:0] exp,
                                input logic [31:0] got);
      checks++;
      assert (got === exp)
      else
      begin
         $display("mismatch at %0d ns: %s expected 0x%0h got 0x%0h", $time, sig, exp, got);
         errors++;
      end
   endtask

   task automatic note_timeout(input string what);
      $display("timeout at %0d ns: %s", $time, what);
      timed_out = 1'b1;
      errors++;
   endtask

   task automatic finish_test(input string name, input int err_start);
      if (errors == err_start)
         $display("test %s: ok", name);
      else
         $display("test %s: %0d errors", name, errors - err_start);
   endtask

   // ssel is active low
   task automatic select_slave();
      @(posedge fpga_clk);
      spi_ssel <= 1'b0;
      repeat (SCK_HALF) @(posedge fpga_clk);
   endtask

   task automatic release_slave();
      @(posedge fpga_clk);
      spi_ssel <= 1'b1;
      repeat (2 * SCK_HALF) @(posedge fpga_clk);
   endtask

   // mode 0 byte, msb first, miso read just before the rising sck
   task automatic spi_xfer(input logic [7:0] tx, output logic [7:0] rx);
      for (int i = 7; i >= 0; i--)
      begin
         spi_mosi <= tx[i];
         repeat (SCK_HALF - 1) @(posedge fpga_clk);
         @(negedge fpga_clk);
         rx[i] = spi_miso;
         @(posedge fpga_clk);
         spi_sck <= 1'b1;
         repeat (SCK_HALF) @(posedge fpga_clk);
         spi_sck <= 1'b0;
      end
   endtask

   task automatic write_ctrl(input logic start, input logic debug, input delay_t delay,
                             input logic soft_rst);
      ctrl_t      c;
      logic [7:0] rx;
      c            = '0;
      c.start      = start;
      c.debug      = debug;
      c.delay      = delay;
      c.soft_reset = soft_rst;
      select_slave();
      spi_xfer(CMD_WR_CTRL, rx);
      spi_xfer(c, rx);
      release_slave();
   endtask

   task automatic read_status(output status_t st);
      logic [7:0] rx;
      select_slave();
      spi_xfer(CMD_RD_STATUS, rx);
      spi_xfer(8'h00, rx);
      st = status_t'(rx);
      release_slave();
   endtask

   // whole record at three bytes per sample
   task automatic read_samples();
      logic [7:0] b0;
      logic [7:0] b1;
      logic [7:0] b2;
      select_slave();
      spi_xfer(CMD_RD_SAMPLES, b0);
      for (int i = 0; i < REC_DEPTH; i++)
      begin
         spi_xfer(8'h00, b0);
         spi_xfer(8'h00, b1);
         spi_xfer(8'h00, b2);
         rec[i] = {b0, b1, b2};
      end
      release_slave();
   endtask

   // debug counter steps by one per strobe
   task automatic check_increment();
      for (int i = 1; i < REC_DEPTH; i++)
         compare_value($sformatf("sample[%0d]", i), sample_t'(rec[i-1] + 1), rec[i]);
   endtask

   task automatic wait_led(input logic level);
      int n;
      n = 0;
      @(negedge fpga_clk);
      while (led !== level && n < LED_LIMIT)
      begin
         @(negedge fpga_clk);
         n++;
      end
      if (led !== level)
         note_timeout($sformatf("led did not reach %0b", level));
   endtask

   task automatic wait_strobe(output int unsigned at);
      int   n;
      logic seen;
      n    = 0;
      seen = 1'b0;
      at   = 0;
      while (!seen && n < STB_LIMIT)
      begin
         @(negedge fpga_clk);
         n++;
         if (sample_test_pin)
         begin
            seen = 1'b1;
            at   = cyc;
         end
      end
      if (!seen)
         note_timeout("no pulse on sample_test_pin");
   endtask

   initial
   begin
      status_t     st;
      delay_t      d1;
      delay_t      d2;
      sample_t     ant_val;
      sample_t     last_old;
      int unsigned t0;
      int unsigned t1;
      int unsigned t2;
      int unsigned t3;
      int          err_start;

      seed      = 28641;
      checks    = 0;
      errors    = 0;
      timed_out = 1'b0;
      arst_n    = 1'b0;
      antenna   = '0;
      spi_sck   = 1'b0;
      spi_mosi  = 1'b0;
      spi_ssel  = 1'b1;
      repeat (RST_CYCLES) @(posedge fpga_clk);
      arst_n <= 1'b1;
      repeat (4) @(posedge fpga_clk);

      // after reset only status bit 0 is set
      err_start = errors;
      @(negedge fpga_clk);
      compare_value("led", 0, led);
      read_status(st);
      compare_value("status", 8'h01, st);
      finish_test("1 reset state", err_start);

      err_start = errors;
      d1 = delay_t'($unsigned($random(seed)) % SAMPLE_DIV);
      write_ctrl(1'b0, 1'b1, d1, 1'b0);
      read_status(st);
      compare_value("status.debug", 1, st.debug);
      compare_value("status.delay", d1, st.delay);
      finish_test("2 control round trip", err_start);

      err_start = errors;
      write_ctrl(1'b1, 1'b1, d1, 1'b0);
      wait_led(1'b1);
      read_samples();
      check_increment();
      last_old = rec[REC_DEPTH-1];
      read_status(st);
      compare_value("status.overflow", 0, st.overflow);
      compare_value("status.done", 1, st.done);
      finish_test("3 debug record", err_start);

      // soft reset also drops start for the next rising edge
      err_start = errors;
      ant_val = sample_t'($random(seed));
      antenna <= ant_val;
      write_ctrl(1'b0, 1'b0, d1, 1'b1);
      write_ctrl(1'b1, 1'b0, d1, 1'b0);
      wait_led(1'b1);
      read_samples();
      for (int i = 0; i < REC_DEPTH; i++)
         compare_value($sformatf("sample[%0d]", i), ant_val, rec[i]);
      read_status(st);
      compare_value("status.overflow", 0, st.overflow);
      finish_test("4 antenna record", err_start);

      err_start = errors;
      write_ctrl(1'b0, 1'b1, d1, 1'b1);
      @(negedge fpga_clk);
      compare_value("led", 0, led);
      write_ctrl(1'b1, 1'b1, d1, 1'b0);
      wait_led(1'b1);
      read_samples();
      check_increment();
      // counter keeps running, so a fresh record starts past the old one
      checks++;
      assert (rec[0] > last_old)
      else
      begin
         $display("mismatch at %0d ns: sample[0] expected above 0x%0h got 0x%0h",
                  $time, last_old, rec[0]);
         errors++;
      end
      read_status(st);
      compare_value("status.overflow", 0, st.overflow);
      finish_test("5 soft reset and restart", err_start);

      err_start = errors;
      d1 = delay_t'($unsigned($random(seed)) % SAMPLE_DIV);
      // second delay always differs from the first
      d2 = delay_t'((d1 + 1 + $unsigned($random(seed)) % (SAMPLE_DIV - 1)) % SAMPLE_DIV);
      write_ctrl(1'b0, 1'b0, d1, 1'b0);
      wait_strobe(t0);
      wait_strobe(t1);
      compare_value("strobe spacing", SAMPLE_DIV, t1 - t0);
      write_ctrl(1'b0, 1'b0, d2, 1'b0);
      wait_strobe(t2);
      wait_strobe(t3);
      compare_value("strobe spacing", SAMPLE_DIV, t3 - t2);
      // phase moves by the delay difference
      compare_value("strobe phase", (int'(d2) - int'(d1) + SAMPLE_DIV) % SAMPLE_DIV,
                    (t2 - t0) % SAMPLE_DIV);
      finish_test("6 strobe phase", err_start);

      assert_errs = u_tart_capture_top.u_tart_capture_props.err_cnt;
      $display("checks %0d, check errors %0d, assertion errors %0d", checks, errors,
               assert_errs);
      if (errors == 0 && assert_errs == 0 && !timed_out)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== dv/tart_capture_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module tart_capture_props
(
   input wire                     fpga_clk,
   input wire                     arst_n,
   input wire tart_pkg::mem_req_t wr_req,
   input wire tart_pkg::mem_req_t rd_req,
   input wire                     wr_gnt,
   input wire                     rd_gnt,
   input wire                     rd_valid,
   input wire                     start,
   input wire                     soft_reset,
   input wire                     running,
   input wire                     done,
   input wire                     overflow
);

   // bumped by every failing property
   int err_cnt = 0;

   // one memory port, so one winner per cycle
   a_one_grant: assert property (@(posedge fpga_clk) disable iff (!arst_n)
      !(wr_gnt && rd_gnt))
   else
   begin
      $error("both memory ports granted in one cycle");
      err_cnt++;
   end

   a_wr_gnt_req: assert property (@(posedge fpga_clk) disable iff (!arst_n)
      wr_gnt |-> wr_req.en)
   else
   begin
      $error("write port granted without a request");
      err_cnt++;
   end

   a_rd_gnt_req: assert property (@(posedge fpga_clk) disable iff (!arst_n)
      rd_gnt |-> rd_req.en)
   else
   begin
      $error("read port granted without a request");
      err_cnt++;
   end

   // registered ram read
   a_rd_valid_after: assert property (@(posedge fpga_clk) disable iff (!arst_n)
      rd_gnt |=> rd_valid)
   else
   begin
      $error("read grant not followed by read valid");
      err_cnt++;
   end

   a_rd_valid_only: assert property (@(posedge fpga_clk) disable iff (!arst_n)
      rd_valid |-> $past(rd_gnt))
   else
   begin
      $error("read valid without a read grant one cycle before");
      err_cnt++;
   end

   // done only drops after a soft reset pulse or a rising start
   a_done_hold: assert property (@(posedge fpga_clk) disable iff (!arst_n)
      $fell(done) |-> ($past(soft_reset) || ($past(start) && !$past(start, 2))))
   else
   begin
      $error("done dropped without soft reset or new start");
      err_cnt++;
   end

   // write port has priority, buffer never laps the scheduler
   a_no_overflow: assert property (@(posedge fpga_clk) disable iff (!arst_n)
      running |-> !overflow)
   else
   begin
      $error("block buffer overflow during acquisition");
      err_cnt++;
   end

endmodule

`default_nettype wire

// ==== verilog/tart_capture_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tart_capture_top
(
   input  wire                   fpga_clk,
   input  wire                   arst_n,
   input  wire tart_pkg::sample_t antenna,
   input  wire                   spi_sck,
   input  wire                   spi_mosi,
   input  wire                   spi_ssel,
   output logic                  spi_miso,
   output logic                  led,
   output logic                  sample_test_pin
);
   import tart_pkg::*;

   bb_ptr_t  wr_ptr;
   bb_ptr_t  rd_ptr;
   sample_t  bb_data;
   sample_t  rd_data;
   mem_req_t wr_req;
   mem_req_t rd_req;
   ctrl_t    ctrl;
   logic     sample_stb;
   logic     soft_reset;
   logic     running;
   logic     done;
   logic     overflow;
   logic     wr_gnt;
   logic     rd_gnt;
   logic     rd_valid;

   // record complete on the led, strobe on a test pin
   assign led             = done;
   assign sample_test_pin = sample_stb;

   antenna_capture u_antenna_capture
   (
      .fpga_clk   (fpga_clk),
      .arst_n     (arst_n),
      .antenna    (antenna),
      .debug      (ctrl.debug),
      .delay      (ctrl.delay),
      .rd_ptr     (rd_ptr),
      .sample_stb (sample_stb),
      .wr_ptr     (wr_ptr),
      .rd_data    (bb_data)
   );

   acq_scheduler u_acq_scheduler
   (
      .fpga_clk   (fpga_clk),
      .arst_n     (arst_n),
      .start      (ctrl.start),
      .soft_reset (soft_reset),
      .wr_ptr     (wr_ptr),
      .bb_data    (bb_data),
      .gnt        (wr_gnt),
      .rd_ptr     (rd_ptr),
      .req        (wr_req),
      .running    (running),
      .done       (done),
      .overflow   (overflow)
   );

   mem_arbiter u_mem_arbiter
   (
      .fpga_clk (fpga_clk),
      .arst_n   (arst_n),
      .wr_req   (wr_req),
      .rd_req   (rd_req),
      .wr_gnt   (wr_gnt),
      .rd_gnt   (rd_gnt),
      .rd_valid (rd_valid),
      .rd_data  (rd_data)
   );

   spi_readout u_spi_readout
   (
      .fpga_clk   (fpga_clk),
      .arst_n     (arst_n),
      .spi_sck    (spi_sck),
      .spi_mosi   (spi_mosi),
      .spi_ssel   (spi_ssel),
      .running    (running),
      .done       (done),
      .overflow   (overflow),
      .gnt        (rd_gnt),
      .rd_valid   (rd_valid),
      .rd_data    (rd_data),
      .spi_miso   (spi_miso),
      .ctrl       (ctrl),
      .soft_reset (soft_reset),
      .req        (rd_req)
   );

endmodule

`default_nettype wire

// ==== verilog/spi_readout.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_readout
(
   input  wire                   fpga_clk,
   input  wire                   arst_n,
   input  wire                   spi_sck,
   input  wire                   spi_mosi,
   input  wire                   spi_ssel,
   input  wire                   running,
   input  wire                   done,
   input  wire                   overflow,
   input  wire                   gnt,
   input  wire                   rd_valid,
   input  wire tart_pkg::sample_t rd_data,
   output logic                  spi_miso,
   output tart_pkg::ctrl_t       ctrl,
   output logic                  soft_reset,
   output tart_pkg::mem_req_t    req
);
   import tart_pkg::*;

   logic [2:0] sck_q;
   logic [1:0] mosi_q;
   logic [1:0] ssel_q;
   logic       sck_rise;
   logic       sck_fall;
   logic       active;
   logic       byte_end;
   logic       cmd_end;
   logic [2:0] bit_cnt;
   logic [1:0] byte_cnt;
   logic [7:0] rx_sh;
   logic [7:0] rx_byte;
   logic [7:0] tx_sh;
   logic [7:0] cmd;
   logic [1:0] sub;
   ctrl_t      wr_byte;
   status_t    status;
   sample_t    word;
   sample_t    pre_word;
   logic       req_en;
   rec_addr_t  rd_addr;

   // edges seen after the synchronizer, ssel active low
   assign sck_rise = sck_q[1] & ~sck_q[2];
   assign sck_fall = ~sck_q[1] & sck_q[2];
   assign active   = ~ssel_q[1];
   assign rx_byte  = {rx_sh[6:0], mosi_q[1]};
   assign wr_byte  = ctrl_t'(rx_byte);
   assign byte_end = active & sck_rise & (bit_cnt == 3'd7);
   assign cmd_end  = byte_end & (byte_cnt == 2'd0);
   assign spi_miso = tx_sh[7];

   always_comb
   begin
      status.done     = done;
      status.running  = running;
      status.overflow = overflow;
      status.debug    = ctrl.debug;
      status.delay    = ctrl.delay;
      status.one      = 1'b1;
      req.en          = req_en;
      req.we          = 1'b0;
      req.addr        = rd_addr;
      req.wdata       = '0;
   end

   // two flops per pin, third sck flop for edges
   always_ff @(posedge fpga_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         sck_q  <= '0;
         mosi_q <= '0;
         ssel_q <= 2'b11;
      end
      else
      begin
         sck_q  <= {sck_q[1:0], spi_sck};
         mosi_q <= {mosi_q[0], spi_mosi};
         ssel_q <= {ssel_q[0], spi_ssel};
      end
   end

   // receive side, command byte then control write
   always_ff @(posedge fpga_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         bit_cnt    <= '0;
         byte_cnt   <= '0;
         rx_sh      <= '0;
         cmd        <= '0;
         ctrl       <= '0;
         soft_reset <= 1'b0;
      end
      else
      begin
         soft_reset <= 1'b0;
         if (!active)
         begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
         end
         else if (sck_rise)
         begin
            rx_sh   <= rx_byte;
            bit_cnt <= bit_cnt + 3'd1;
         end
         if (byte_end)
         begin
            // saturate, only first two bytes matter
            if (byte_cnt != 2'd3)
               byte_cnt <= byte_cnt + 2'd1;
            if (cmd_end)
               cmd <= rx_byte;
            else if (byte_cnt == 2'd1 && cmd == CMD_WR_CTRL)
            begin
               ctrl.start <= wr_byte.start;
               ctrl.debug <= wr_byte.debug;
               ctrl.delay <= wr_byte.delay;
               // soft reset is a pulse, not stored
               soft_reset <= wr_byte.soft_reset;
            end
         end
      end
   end

   // transmit side and sample prefetch
   always_ff @(posedge fpga_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         tx_sh    <= '0;
         sub      <= '0;
         word     <= '0;
         pre_word <= '0;
         req_en   <= 1'b0;
         rd_addr  <= '0;
      end
      else
      begin
         if (gnt)
         begin
            req_en  <= 1'b0;
            rd_addr <= rd_addr + rec_addr_t'(1);
         end
         if (rd_valid)
            pre_word <= rd_data;
         // fetch sample 0 while the first byte goes out
         if (cmd_end && rx_byte == CMD_RD_SAMPLES)
         begin
            req_en  <= 1'b1;
            rd_addr <= '0;
            sub     <= '0;
         end
         if (!active)
         begin
            tx_sh <= '0;
            sub   <= '0;
         end
         else if (sck_fall)
         begin
            // mid byte, shift; byte boundary, load next
            if (bit_cnt != 3'd0)
               tx_sh <= {tx_sh[6:0], 1'b0};
            else if (cmd == CMD_RD_STATUS)
               tx_sh <= status;
            else if (cmd == CMD_RD_SAMPLES)
            begin
               if (sub == 2'd0)
               begin
                  tx_sh  <= pre_word[23:16];
                  word   <= {pre_word[15:0], 8'h00};
                  req_en <= 1'b1;
                  sub    <= 2'd1;
               end
               else
               begin
                  tx_sh <= word[23:16];
                  word  <= {word[15:0], 8'h00};
                  sub   <= (sub == 2'd2) ? 2'd0 : sub + 2'd1;
               end
            end
            else
               tx_sh <= 8'h00;
         end
      end
   end

endmodule

`default_nettype wire

// ==== verilog/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
(
   input  wire                    fpga_clk,
   input  wire                    arst_n,
   input  wire tart_pkg::mem_req_t wr_req,
   input  wire tart_pkg::mem_req_t rd_req,
   output logic                   wr_gnt,
   output logic                   rd_gnt,
   output logic                   rd_valid,
   output tart_pkg::sample_t      rd_data
);
   import tart_pkg::*;

   mem_req_t mem_req;

   // acquisition always first, readout takes the gaps
   assign wr_gnt = wr_req.en;
   assign rd_gnt = rd_req.en & ~wr_req.en;

   // winner drives the single port
   always_comb
   begin
      mem_req    = wr_gnt ? wr_req : rd_req;
      mem_req.en = wr_gnt | rd_gnt;
      mem_req.we = wr_gnt & wr_req.we;
   end

   // data from the ram lands one cycle after the grant
   always_ff @(posedge fpga_clk or negedge arst_n)
   begin
      if (!arst_n)
         rd_valid <= 1'b0;
      else
         rd_valid <= rd_gnt;
   end

   sample_mem u_sample_mem
   (
      .fpga_clk (fpga_clk),
      .en       (mem_req.en),
      .we       (mem_req.we),
      .addr     (mem_req.addr),
      .wdata    (mem_req.wdata),
      .rdata    (rd_data)
   );

endmodule

`default_nettype wire

// ==== verilog/acq_scheduler.sv ====
`timescale 1ns/1ps
`default_nettype none

module acq_scheduler
(
   input  wire                   fpga_clk,
   input  wire                   arst_n,
   input  wire                   start,
   input  wire                   soft_reset,
   input  wire tart_pkg::bb_ptr_t wr_ptr,
   input  wire tart_pkg::sample_t bb_data,
   input  wire                   gnt,
   output tart_pkg::bb_ptr_t     rd_ptr,
   output tart_pkg::mem_req_t    req,
   output logic                  running,
   output logic                  done,
   output logic                  overflow
);
   import tart_pkg::*;

   typedef enum logic [1:0] {S_IDLE, S_RUN, S_DONE} state_t;

   state_t    state;
   logic      start_d;
   logic      start_rise;
   logic      bb_empty;
   logic      bb_wrapped;
   bb_ptr_t   wr_ptr_d;
   rec_addr_t wr_addr;

   assign start_rise = start & ~start_d;
   assign bb_empty   = (rd_ptr == wr_ptr);
   // writer moved and landed on the oldest unread word
   assign bb_wrapped = (wr_ptr != wr_ptr_d) && bb_empty;

   assign running = (state == S_RUN);
   assign done    = (state == S_DONE);

   // one write per buffered word, held until granted
   always_comb
   begin
      req.en    = running & ~bb_empty;
      req.we    = 1'b1;
      req.addr  = wr_addr;
      req.wdata = bb_data;
   end

   always_ff @(posedge fpga_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state    <= S_IDLE;
         start_d  <= 1'b0;
         wr_ptr_d <= '0;
         rd_ptr   <= '0;
         wr_addr  <= '0;
         overflow <= 1'b0;
      end
      else
      begin
         start_d  <= start;
         wr_ptr_d <= wr_ptr;
         // new record, skip anything already buffered
         if (start_rise)
         begin
            state    <= S_RUN;
            rd_ptr   <= wr_ptr;
            wr_addr  <= '0;
            overflow <= 1'b0;
         end
         else if (soft_reset)
         begin
            state    <= S_IDLE;
            rd_ptr   <= wr_ptr;
            wr_addr  <= '0;
            overflow <= 1'b0;
         end
         else if (state == S_RUN)
         begin
            if (bb_wrapped)
               overflow <= 1'b1;
            // grant ends the word
            if (gnt)
            begin
               rd_ptr  <= rd_ptr + bb_ptr_t'(1);
               wr_addr <= wr_addr + rec_addr_t'(1);
               if (wr_addr == rec_addr_t'(REC_DEPTH - 1))
                  state <= S_DONE;
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== verilog/antenna_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module antenna_capture
(
   input  wire                   fpga_clk,
   input  wire                   arst_n,
   input  wire tart_pkg::sample_t antenna,
   input  wire                   debug,
   input  wire tart_pkg::delay_t  delay,
   input  wire tart_pkg::bb_ptr_t rd_ptr,
   output logic                  sample_stb,
   output tart_pkg::bb_ptr_t     wr_ptr,
   output tart_pkg::sample_t     rd_data
);
   import tart_pkg::*;

   logic [2:0] div_cnt;
   delay_t     delay_q;
   sample_t    ant_q;
   sample_t    dbg_cnt;
   sample_t    sample_sel;
   logic       bb_we;
   sample_t    bb_mem [BB_DEPTH];

   // divide by six, phase compare against the latched delay
   // delay only taken at wrap, so one strobe per period
   always_ff @(posedge fpga_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         div_cnt    <= '0;
         delay_q    <= '0;
         sample_stb <= 1'b0;
      end
      else
      begin
         sample_stb <= (div_cnt == delay_q);
         if (div_cnt == 3'(SAMPLE_DIV - 1))
         begin
            div_cnt <= '0;
            // clip out of range phases
            delay_q <= (delay > delay_t'(SAMPLE_DIV - 1)) ? delay_t'(SAMPLE_DIV - 1) : delay;
         end
         else
            div_cnt <= div_cnt + 3'd1;
      end
   end

   // debug counter and buffer write pointer
   always_ff @(posedge fpga_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         dbg_cnt <= '0;
         bb_we   <= 1'b0;
         wr_ptr  <= '0;
      end
      else
      begin
         bb_we <= sample_stb;
         if (sample_stb)
            dbg_cnt <= dbg_cnt + sample_t'(1);
         if (bb_we)
            wr_ptr <= wr_ptr + bb_ptr_t'(1);
      end
   end

   // real or fake antenna data
   assign sample_sel = debug ? dbg_cnt : ant_q;

   // input register and circular buffer, payload only
   always_ff @(posedge fpga_clk)
   begin
      if (sample_stb)
         ant_q <= antenna;
      if (bb_we)
         bb_mem[wr_ptr] <= sample_sel;
   end

   // async read for the scheduler
   assign rd_data = bb_mem[rd_ptr];

endmodule

`default_nettype wire

// ==== verilog/sample_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_mem
(
   input  wire                  fpga_clk,
   input  wire                  en,
   input  wire                  we,
   input  wire tart_pkg::rec_addr_t addr,
   input  wire tart_pkg::sample_t   wdata,
   output tart_pkg::sample_t    rdata
);
   import tart_pkg::*;

   // block ram, one port
   sample_t mem [REC_DEPTH];

   // write in the enable cycle, read data one cycle later
   always_ff @(posedge fpga_clk)
   begin
      if (en)
      begin
         if (we)
            mem[addr] <= wdata;
         rdata <= mem[addr];
      end
   end

endmodule

`default_nettype wire

// ==== verilog/tart_pkg.sv ====
`default_nettype none

package tart_pkg;

   // one bit per antenna, so one word holds one sample
   localparam int NUM_ANT = 24;
   typedef logic [NUM_ANT-1:0] sample_t;

   // receiver clock ratio
   localparam int SAMPLE_DIV = 6;
   // strobe phase, values above 5 act as 5
   typedef logic [2:0] delay_t;

   // block buffer between strobe and memory
   localparam int BB_DEPTH = 16;
   typedef logic [$clog2(BB_DEPTH)-1:0] bb_ptr_t;

   // fixed-length sample record
   localparam int REC_DEPTH = 64;
   typedef logic [$clog2(REC_DEPTH)-1:0] rec_addr_t;

   // one memory request, held until granted
   typedef struct packed {
      logic      en;
      logic      we;
      rec_addr_t addr;
      sample_t   wdata;
   } mem_req_t;

   // spi command bytes
   localparam logic [7:0] CMD_WR_CTRL    = 8'h01;
   localparam logic [7:0] CMD_RD_STATUS  = 8'h02;
   localparam logic [7:0] CMD_RD_SAMPLES = 8'h03;

   typedef struct packed {
      logic      soft_reset;
      logic [1:0] rsvd;
      delay_t    delay;
      logic      debug;
      logic      start;
   } ctrl_t;

   // bit 0 reads as one so a dead bus is obvious
   typedef struct packed {
      logic   done;
      logic   running;
      logic   overflow;
      logic   debug;
      delay_t delay;
      logic   one;
   } status_t;

endpackage

`default_nettype wire
